// File: source/npc_settings.svh
`ifndef NPC_SETTINGS_SVH
`define NPC_SETTINGS_SVH

// ******************************
// core wide constants
// ******************************

// data and address width of rv64
`define NPC_XLEN 64

// general register count
`define NPC_NREG 32

// bits needed to name one register
`define NPC_REG_W 5

// first fetch address after reset
`define NPC_RESET_PC 64'h8000_0000

`endif

// File: source/npc_pkg.sv
`include "npc_settings.svh"

package npc_pkg;

	// ******************************
	// plain vector types
	// ******************************

	// data word or address
	typedef logic [`NPC_XLEN-1:0] xlen_t;
	// raw instruction word
	typedef logic [31:0] inst_t;
	// register index
	typedef logic [`NPC_REG_W-1:0] reg_id_t;

	// alu operations of the supported subset
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_IMM,    // lui passes the immediate
		ALU_BEQ,
		ALU_BNE
	} alu_op_e;

	// ******************************
	// stage payloads
	// ******************************

	// fetch to decode
	typedef struct packed {
		xlen_t pc;
		inst_t inst;
	} if_id_t;

	// decode to execute, operands already read
	typedef struct packed {
		xlen_t   pc;
		alu_op_e alu_op;
		reg_id_t rd;
		logic    rd_wen;
		xlen_t   src_a;
		xlen_t   src_b;
		xlen_t   imm;
	} id_ex_t;

	// execute to writeback
	typedef struct packed {
		xlen_t   pc;
		reg_id_t rd;
		logic    rd_wen;
		xlen_t   result;
	} ex_wb_t;

	// one retired instruction
	typedef struct packed {
		xlen_t   pc;
		reg_id_t rd;
		logic    rd_wen;
		xlen_t   wdata;
	} retire_t;

endpackage

// File: source/npc_regfile.sv
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_regfile import npc_pkg::*; (
	input  logic    clk,
	// read ports
	input  reg_id_t rs1,
	input  reg_id_t rs2,
	output xlen_t   rdata1,
	output xlen_t   rdata2,
	// write port from writeback
	input  logic    wen,
	input  reg_id_t waddr,
	input  xlen_t   wdata
);

	// storage, entry 0 never written
	xlen_t regs [`NPC_NREG];

	// ******************************
	// write
	// ******************************

	always_ff @(posedge clk) begin
		// x0 stays zero
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// ******************************
	// read with write-through
	// ******************************

	always_comb begin
		if (rs1 == '0) begin
			rdata1 = '0;
		end else if (wen && waddr == rs1) begin
			// value being written this cycle
			rdata1 = wdata;
		end else begin
			rdata1 = regs[rs1];
		end
	end

	always_comb begin
		if (rs2 == '0) begin
			rdata2 = '0;
		end else if (wen && waddr == rs2) begin
			rdata2 = wdata;
		end else begin
			rdata2 = regs[rs2];
		end
	end

endmodule

// File: source/npc_ifu.sv
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_ifu import npc_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	// instruction port
	output xlen_t  imem_addr,
	input  logic   imem_valid,
	input  inst_t  imem_data,
	// to decode
	output logic   if_valid,
	input  logic   if_ready,
	output if_id_t if_data,
	// branch redirect from execute
	input  logic   redirect,
	input  xlen_t  redirect_pc
);

	// address of the next fetch
	xlen_t pc;
	// a fetch is taken this cycle
	logic  fetch;

	// request always points at pc
	assign imem_addr = pc;

	// ******************************
	// fetch condition
	// ******************************

	// port answered and the output slot is free or leaving
	assign fetch = imem_valid && (!if_valid || if_ready);

	// ******************************
	// pc and output valid
	// ******************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc       <= `NPC_RESET_PC;
			if_valid <= 1'b0;
		end else if (redirect) begin
			// taken branch wins over any fetch
			pc       <= redirect_pc;
			if_valid <= 1'b0;
		end else if (fetch) begin
			pc       <= pc + xlen_t'(4);
			if_valid <= 1'b1;
		end else if (if_ready) begin
			// slot drained, nothing new
			if_valid <= 1'b0;
		end
	end

	// ******************************
	// output payload
	// ******************************

	// held while decode stalls
	always_ff @(posedge clk) begin
		if (fetch && !redirect) begin
			if_data.pc   <= pc;
			if_data.inst <= imem_data;
		end
	end

endmodule

// File: source/npc_idu.sv
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_idu import npc_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	// from fetch
	input  logic    if_valid,
	output logic    if_ready,
	input  if_id_t  if_data,
	// register file read
	output reg_id_t rs1,
	output reg_id_t rs2,
	input  xlen_t   rdata1,
	input  xlen_t   rdata2,
	// scoreboard clear from writeback
	input  logic    clr_valid,
	input  reg_id_t clr_rd,
	// flush
	input  logic    redirect,
	// to execute
	output logic    id_valid,
	input  logic    id_ready,
	output id_ex_t  id_data
);

	// major opcodes of the subset
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_BR  = 7'b1100011;

	inst_t inst;
	logic [6:0] funct7;
	logic [2:0] funct3;
	logic r_ok;
	// immediates of each format
	xlen_t imm_i, imm_u, imm_b;

	// decode results
	alu_op_e dec_op;
	reg_id_t dec_rd;
	logic    dec_wen;
	xlen_t   dec_imm;
	logic    use_rs1, use_rs2, use_imm;

	// scoreboard
	logic [`NPC_NREG-1:0] busy, busy_next, clr_mask, pend;
	logic stall, load;

	assign inst   = if_data.inst;
	assign funct7 = inst[31:25];
	assign funct3 = inst[14:12];

	// ******************************
	// immediate generation
	// ******************************

	assign imm_i = {{(`NPC_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u = {{(`NPC_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_b = {{(`NPC_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

	// add sub xor or and only
	assign r_ok = (funct7 == 7'h00 && funct3 inside {3'h0, 3'h4, 3'h6, 3'h7})
		|| (funct7 == 7'h20 && funct3 == 3'h0);

	// ******************************
	// decoder
	// ******************************

	always_comb begin
		// default is addi x0, x0, 0
		dec_op  = ALU_ADD;
		dec_rd  = '0;
		dec_wen = 1'b1;
		dec_imm = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_imm = 1'b1;
		case (inst[6:0])
			OP_IMM: if (funct3 == 3'h0) begin
				dec_rd  = inst[11:7];
				dec_imm = imm_i;
				use_rs1 = 1'b1;
			end
			OP_REG: if (r_ok) begin
				dec_rd  = inst[11:7];
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_imm = 1'b0;
				case (funct3)
					3'h4:    dec_op = ALU_XOR;
					3'h6:    dec_op = ALU_OR;
					3'h7:    dec_op = ALU_AND;
					default: dec_op = funct7[5] ? ALU_SUB : ALU_ADD;
				endcase
			end
			OP_LUI: begin
				dec_op  = ALU_IMM;
				dec_rd  = inst[11:7];
				dec_imm = imm_u;
			end
			OP_BR: if (funct3 == 3'h0 || funct3 == 3'h1) begin
				dec_op  = funct3[0] ? ALU_BNE : ALU_BEQ;
				dec_wen = 1'b0;
				dec_imm = imm_b;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_imm = 1'b0;
			end
			default: ;
		endcase
	end

	// unused source reads x0
	assign rs1 = use_rs1 ? inst[19:15] : '0;
	assign rs2 = use_rs2 ? inst[24:20] : '0;

	// ******************************
	// scoreboard stall
	// ******************************

	// a register cleared this cycle is readable through the bypass
	assign clr_mask = clr_valid ? (`NPC_NREG'(1) << clr_rd) : '0;
	assign pend     = busy & ~clr_mask;

	// rd checked too so an older write cannot clear a younger claim
	assign stall = if_valid && ((use_rs1 && pend[rs1]) || (use_rs2 && pend[rs2])
		|| (dec_wen && pend[dec_rd]));

	assign if_ready = (!id_valid || id_ready) && !stall;
	assign load     = if_valid && if_ready && !redirect;

	always_comb begin
		busy_next = busy & ~clr_mask;
		// set after clear so a new claim survives
		if (load && dec_wen && dec_rd != '0) begin
			busy_next[dec_rd] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= '0;
		end else begin
			busy <= busy_next;
		end
	end

	// ******************************
	// id/ex register
	// ******************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid <= 1'b0;
		end else if (redirect) begin
			id_valid <= 1'b0;
		end else if (!id_valid || id_ready) begin
			id_valid <= load;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			id_data <= '{pc: if_data.pc, alu_op: dec_op, rd: dec_rd, rd_wen: dec_wen,
				src_a: rdata1, src_b: use_imm ? dec_imm : rdata2, imm: dec_imm};
		end
	end

endmodule

// File: source/npc_exu.sv
`timescale 1ns/1ps

module npc_exu import npc_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	// from decode
	input  logic   id_valid,
	output logic   id_ready,
	input  id_ex_t id_data,
	// branch redirect to fetch and decode
	output logic   redirect,
	output xlen_t  redirect_pc,
	// to writeback
	output logic   ex_valid,
	input  logic   ex_ready,
	output ex_wb_t ex_data
);

	xlen_t result;
	logic  taken;
	logic  accept;

	// ******************************
	// alu
	// ******************************

	always_comb begin
		case (id_data.alu_op)
			ALU_ADD: result = id_data.src_a + id_data.src_b;
			ALU_SUB: result = id_data.src_a - id_data.src_b;
			ALU_XOR: result = id_data.src_a ^ id_data.src_b;
			ALU_OR:  result = id_data.src_a | id_data.src_b;
			ALU_AND: result = id_data.src_a & id_data.src_b;
			ALU_IMM: result = id_data.imm;
			// branches write nothing
			default: result = '0;
		endcase
	end

	// ******************************
	// branch resolve
	// ******************************

	always_comb begin
		case (id_data.alu_op)
			ALU_BEQ: taken = (id_data.src_a == id_data.src_b);
			ALU_BNE: taken = (id_data.src_a != id_data.src_b);
			default: taken = 1'b0;
		endcase
	end

	// output slot empty or draining
	assign id_ready = !ex_valid || ex_ready;
	assign accept   = id_valid && id_ready;

	// one cycle pulse, decode empties behind the branch
	assign redirect    = accept && taken;
	assign redirect_pc = id_data.pc + id_data.imm;

	// ******************************
	// ex/wb register
	// ******************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
		end else if (id_ready) begin
			ex_valid <= id_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ex_data.pc     <= id_data.pc;
			ex_data.rd     <= id_data.rd;
			ex_data.rd_wen <= id_data.rd_wen;
			ex_data.result <= result;
		end
	end

endmodule

// File: source/npc_wbu.sv
`timescale 1ns/1ps

module npc_wbu import npc_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	// from execute
	input  logic    ex_valid,
	output logic    ex_ready,
	input  ex_wb_t  ex_data,
	// register file write
	output logic    wen,
	output reg_id_t waddr,
	output xlen_t   wdata,
	// scoreboard clear
	output logic    clr_valid,
	output reg_id_t clr_rd,
	// retire port
	output logic    retire_valid,
	output retire_t retire
);

	logic   wb_valid;
	ex_wb_t wb_data;

	// never stalls
	assign ex_ready = 1'b1;

	// ******************************
	// writeback register
	// ******************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			wb_data <= ex_data;
		end
	end

	// write, clear and retire together
	assign wen       = wb_valid && wb_data.rd_wen;
	assign waddr     = wb_data.rd;
	assign wdata     = wb_data.result;
	assign clr_valid = wen;
	assign clr_rd    = wb_data.rd;

	assign retire_valid = wb_valid;
	assign retire       = '{pc: wb_data.pc, rd: wb_data.rd, rd_wen: wb_data.rd_wen,
		wdata: wb_data.result};

endmodule

// File: source/npc.sv
`timescale 1ns/1ps

module npc import npc_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	// instruction port
	output xlen_t   imem_addr,
	input  logic    imem_valid,
	input  inst_t   imem_data,
	// retirement
	output logic    retire_valid,
	output retire_t retire
);

	// ******************************
	// stage links
	// ******************************

	logic   if_valid, if_ready;
	if_id_t if_data;
	logic   id_valid, id_ready;
	id_ex_t id_data;
	logic   ex_valid, ex_ready;
	ex_wb_t ex_data;

	// branch redirect
	logic  redirect;
	xlen_t redirect_pc;

	// register file and scoreboard
	reg_id_t rs1, rs2, waddr, clr_rd;
	xlen_t   rdata1, rdata2, wdata;
	logic    wen, clr_valid;

	// ******************************
	// units
	// ******************************

	npc_ifu ifu_i (.clk, .arst_n, .imem_addr, .imem_valid, .imem_data,
		.if_valid, .if_ready, .if_data, .redirect, .redirect_pc);

	npc_idu idu_i (.clk, .arst_n, .if_valid, .if_ready, .if_data,
		.rs1, .rs2, .rdata1, .rdata2, .clr_valid, .clr_rd, .redirect,
		.id_valid, .id_ready, .id_data);

	npc_exu exu_i (.clk, .arst_n, .id_valid, .id_ready, .id_data,
		.redirect, .redirect_pc, .ex_valid, .ex_ready, .ex_data);

	npc_wbu wbu_i (.clk, .arst_n, .ex_valid, .ex_ready, .ex_data,
		.wen, .waddr, .wdata, .clr_valid, .clr_rd, .retire_valid, .retire);

	// general registers
	npc_regfile gpr_i (.clk, .rs1, .rs2, .rdata1, .rdata2, .wen, .waddr, .wdata);

endmodule

// File: bench/npc_asserts.sv
`timescale 1ns/1ps

module npc_asserts import npc_pkg::*; (
	input logic   clk,
	input logic   arst_n,
	input logic   if_valid,
	input logic   if_ready,
	input if_id_t if_data,
	input logic   redirect,
	input logic   retire_valid
);

	// ******************************
	// handshake stability
	// ******************************

	// a held fetch slot keeps valid and payload unless flushed
	assert property (@(posedge clk) disable iff (!arst_n)
		if_valid && !if_ready && !redirect |=> if_valid && $stable(if_data))
		else $error("if/id slot changed while decode held it");

	// ******************************
	// reset and redirect
	// ******************************

	// quiet core during reset
	assert property (@(posedge clk) !arst_n |-> !retire_valid && !redirect)
		else $error("retire or redirect seen during reset");

	// single cycle pulse
	assert property (@(posedge clk) disable iff (!arst_n) redirect |=> !redirect)
		else $error("redirect held longer than one cycle");

endmodule

bind npc npc_asserts asserts_i (
	.clk, .arst_n, .if_valid, .if_ready, .if_data, .redirect, .retire_valid
);

// File: bench/npc_tb.sv
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_tb import npc_pkg::*; ();

	// generated instructions before the closing self-loop
	localparam int PROG_LEN = 96;
	// retirements to check
	localparam int NRET     = 200;
	localparam int TIMEOUT  = 20000;
	// fetch gap pattern length
	localparam int HOLD_LEN = 256;
	// beq x0, x0, 0
	localparam inst_t LOOP_WORD = 32'h0000_0063;

	logic    clk;
	logic    arst_n;
	xlen_t   imem_addr;
	logic    imem_valid = 1'b0;
	inst_t   imem_data;
	logic    retire_valid;
	retire_t retire;

	// program image and fetch gaps
	inst_t prog [PROG_LEN + 1];
	logic  hold [HOLD_LEN];
	int    beat = 0;
	logic [31:0] rng;

	// isa model state
	xlen_t ref_pc = `NPC_RESET_PC;
	xlen_t ref_regs [`NPC_NREG] = '{default: '0};

	int retired    = 0;
	int mismatches = 0;
	int timeouts   = 0;

	npc dut_i (.clk, .arst_n, .imem_addr, .imem_valid, .imem_data, .retire_valid, .retire);

	// ******************************
	// random numbers and encoding
	// ******************************

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// upper half since low lcg bits repeat too fast
	function automatic logic [15:0] draw();
		rng = lcg_next(rng);
		return rng[31:16];
	endfunction

	function automatic inst_t itype_word(logic [11:0] imm, reg_id_t rs1, reg_id_t rd);
		return {imm, rs1, 3'h0, rd, 7'b0010011};
	endfunction

	function automatic inst_t rtype_word(logic [6:0] f7, reg_id_t rs2, reg_id_t rs1,
		logic [2:0] f3, reg_id_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic inst_t utype_word(logic [19:0] imm, reg_id_t rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic inst_t btype_word(logic [12:0] off, reg_id_t rs2, reg_id_t rs1,
		logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	// ******************************
	// program generator
	// ******************************

	function automatic void build_program();
		logic [15:0] r, s, t;
		logic [12:0] off;
		reg_id_t rd, rs1, rs2;
		int i;
		// x1..x7 get known values first
		for (i = 0; i < 7; i++) begin
			t = draw();
			prog[i] = itype_word(t[11:0], '0, reg_id_t'(i + 1));
		end
		for (i = 7; i < PROG_LEN; i++) begin
			r = draw();
			s = draw();
			t = draw();
			rd  = {2'b00, r[2:0]};
			rs1 = {2'b00, r[5:3]};
			rs2 = {2'b00, r[8:6]};
			if (r[15:14] == 2'd0 && i <= PROG_LEN - 4) begin
				// forward 8 to 16 bytes and never past the self-loop
				off = (s[1:0] == 2'd0) ? 13'd8 : (s[1:0] == 2'd1) ? 13'd12 : 13'd16;
				// same register on both sides makes beq taken
				if (r[11]) begin
					rs2 = rs1;
				end
				prog[i] = btype_word(off, rs2, rs1, {2'b00, s[5]});
			end else begin
				case (s[4:2])
					3'd1:    prog[i] = rtype_word(7'h00, rs2, rs1, 3'h0, rd);
					3'd2:    prog[i] = rtype_word(7'h20, rs2, rs1, 3'h0, rd);
					3'd3:    prog[i] = rtype_word(7'h00, rs2, rs1, 3'h4, rd);
					3'd4:    prog[i] = rtype_word(7'h00, rs2, rs1, 3'h6, rd);
					3'd5:    prog[i] = rtype_word(7'h00, rs2, rs1, 3'h7, rd);
					3'd6:    prog[i] = utype_word({s[15:8], t[11:0]}, rd);
					default: prog[i] = itype_word(t[11:0], rs1, rd);
				endcase
			end
		end
		prog[PROG_LEN] = LOOP_WORD;
		// roughly one cycle in four without an answer
		for (i = 0; i < HOLD_LEN; i++) begin
			t = draw();
			hold[i] = (t[1:0] == 2'd0);
		end
	endfunction

	// word at a byte address or a pattern of the whole address outside the image
	function automatic inst_t fetch_word(xlen_t addr);
		xlen_t idx;
		idx = (addr - `NPC_RESET_PC) >> 2;
		if (addr >= `NPC_RESET_PC && idx <= xlen_t'(PROG_LEN)) begin
			return prog[int'(idx)];
		end
		return addr[31:0] ^ addr[63:32] ^ 32'h5a5a_a5a5;
	endfunction

	// ******************************
	// isa reference
	// ******************************

	// executes one instruction at ref_pc and returns its retirement
	function automatic retire_t ref_step();
		inst_t   w;
		retire_t e;
		xlen_t   a, b, res, imm_i, imm_b;
		logic    take;
		w     = fetch_word(ref_pc);
		a     = ref_regs[w[19:15]];
		b     = ref_regs[w[24:20]];
		imm_i = {{(`NPC_XLEN-12){w[31]}}, w[31:20]};
		imm_b = {{(`NPC_XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		res   = '0;
		take  = 1'b0;
		e.pc     = ref_pc;
		e.rd     = w[11:7];
		e.rd_wen = 1'b1;
		case (w[6:0])
			7'b0010011: res = a + imm_i;
			7'b0110111: res = {{(`NPC_XLEN-32){w[31]}}, w[31:12], 12'b0};
			7'b0110011: begin
				case ({w[30], w[14:12]})
					4'b0000: res = a + b;
					4'b1000: res = a - b;
					4'b0100: res = a ^ b;
					4'b0110: res = a | b;
					default: res = a & b;
				endcase
			end
			default: begin
				// beq or bne write no register
				e.rd_wen = 1'b0;
				take = w[12] ? (a != b) : (a == b);
			end
		endcase
		e.wdata = res;
		if (e.rd_wen && e.rd != '0) begin
			ref_regs[e.rd] = res;
		end
		ref_pc = take ? ref_pc + imm_b : ref_pc + xlen_t'(4);
		return e;
	endfunction

	// ******************************
	// clock, memory, compare
	// ******************************

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// combinational instruction port
	always_comb imem_data = fetch_word(imem_addr);

	always @(posedge clk) begin
		if (!arst_n) begin
			imem_valid <= 1'b0;
			beat       <= 0;
		end else begin
			imem_valid <= !hold[beat];
			beat       <= (beat + 1) % HOLD_LEN;
		end
	end

	always @(posedge clk) begin : compare
		retire_t e;
		if (arst_n && retire_valid && retired < NRET) begin
			e = ref_step();
			if (retire.pc !== e.pc) begin
				$display("Mismatch retire.pc #%0d: got %h expected %h", retired, retire.pc, e.pc);
				mismatches++;
			end
			if (retire.rd_wen !== e.rd_wen) begin
				$display("Mismatch retire.rd_wen #%0d: got %h expected %h", retired,
					retire.rd_wen, e.rd_wen);
				mismatches++;
			end
			if (e.rd_wen && retire.rd !== e.rd) begin
				$display("Mismatch retire.rd #%0d: got %h expected %h", retired, retire.rd, e.rd);
				mismatches++;
			end
			// x0 value is never architectural
			if (e.rd_wen && e.rd != '0 && retire.wdata !== e.wdata) begin
				$display("Mismatch retire.wdata #%0d: got %h expected %h", retired,
					retire.wdata, e.wdata);
				mismatches++;
			end
			retired++;
		end
	end

	// ******************************
	// main sequence
	// ******************************

	initial begin
		int cycles;
		arst_n = 1'b0;
		rng    = 32'h3c6f;
		build_program();
		repeat (8) @(posedge clk);
		// fetch points at the reset pc while reset is held
		if (imem_addr !== `NPC_RESET_PC) begin
			$display("Mismatch imem_addr: got %h expected %h", imem_addr, `NPC_RESET_PC);
			mismatches++;
		end
		arst_n <= 1'b1;
		cycles = 0;
		while (retired < NRET && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (retired < NRET) begin
			$display("timeout: only %0d of %0d instructions retired in %0d cycles",
				retired, NRET, cycles);
			timeouts++;
		end
		$display("errors: %0d mismatches, %0d timeouts, %0d retired", mismatches, timeouts,
			retired);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+source
source/npc_pkg.sv
source/npc_regfile.sv
source/npc_ifu.sv
source/npc_idu.sv
source/npc_exu.sv
source/npc_wbu.sv
source/npc.sv
bench/npc_asserts.sv
bench/npc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the npc testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module npc_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vnpc_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1
